// File: common/mdu_pkg.sv
/*
 * Shared definitions for the multiply/divide unit:
 *   operation codes written to the command register
 *   register map of the Wishbone slave
 *   default operand width
 */
package mdu_pkg;

    // operand width used when the top level is not overridden
    localparam int default_width = 32;

    // command codes, anything above op_mtlo starts nothing
    typedef enum logic [2:0] {
        op_mult  = 3'd0, // signed multiply
        op_multu = 3'd1, // unsigned multiply
        op_div   = 3'd2, // signed divide
        op_divu  = 3'd3, // unsigned divide
        op_mthi  = 3'd4, // move operand a to hi
        op_mtlo  = 3'd5  // move operand a to lo
    } mdu_op_t;

    // word addresses on the bus
    typedef enum logic [2:0] {
        reg_a      = 3'd0,
        reg_b      = 3'd1,
        reg_cmd    = 3'd2, // write-only
        reg_hi     = 3'd3,
        reg_lo     = 3'd4,
        reg_status = 3'd5  // bit 0 is busy
    } reg_addr_t;

    // status register bit positions
    localparam int status_busy_bit = 0;

endpackage

// File: source/mdu_wb_slave.sv
/*
 * Wishbone classic slave of the multiply/divide unit.
 * Holds the operand registers, decodes the register map,
 * returns read data with a registered ack and stalls
 * command writes while an operation is busy.
 */
`timescale 1ns/100ps

module mdu_wb_slave #(
    parameter int width = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [2:0]           wb_adr,
    input  logic [width-1:0]     wb_dat_w,
    output logic [width-1:0]     wb_dat_r,
    output logic                 wb_ack,
    input  logic [width-1:0]     hi,
    input  logic [width-1:0]     lo,
    input  logic                 busy,
    output logic [width-1:0]     op_a,
    output logic [width-1:0]     op_b,
    output logic                 start,
    output mdu_pkg::mdu_op_t     op
);

    mdu_pkg::reg_addr_t addr;
    logic               cmd_write;
    logic               hold;
    logic               accept;
    logic               op_known;
    logic [width-1:0]   rd_data;

    assign addr      = mdu_pkg::reg_addr_t'(wb_adr);
    assign cmd_write = wb_we && (addr == mdu_pkg::reg_cmd);
    assign hold      = cmd_write && busy;          // back-pressure on commands
    assign accept    = wb_cyc && wb_stb && !wb_ack && !hold;
    assign op_known  = (wb_dat_w[2:0] <= 3'(mdu_pkg::op_mtlo));

    // read mux, unmapped and write-only addresses return zero
    always_comb begin
        rd_data = '0;
        case (addr)
            mdu_pkg::reg_a:      rd_data = op_a;
            mdu_pkg::reg_b:      rd_data = op_b;
            mdu_pkg::reg_hi:     rd_data = hi;
            mdu_pkg::reg_lo:     rd_data = lo;
            mdu_pkg::reg_status: rd_data[mdu_pkg::status_busy_bit] = busy;
            default:             rd_data = '0;
        endcase
    end

    // ack and start share one edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            start  <= 1'b0;
        end else begin
            wb_ack <= accept;
            start  <= accept && cmd_write && op_known;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (accept) begin
            wb_dat_r <= rd_data;
            if (wb_we && addr == mdu_pkg::reg_a)
                op_a <= wb_dat_w;
            if (wb_we && addr == mdu_pkg::reg_b)
                op_b <= wb_dat_w;
            if (cmd_write)
                op <= mdu_pkg::mdu_op_t'(wb_dat_w[2:0]);
        end
    end

endmodule

// File: mult_div/mdu_mult.sv
/*
 * Two-stage pipelined multiplier.
 * Stage one registers the operands extended by one bit,
 * stage two registers the double-width product.
 */
`timescale 1ns/100ps

module mdu_mult #(
    parameter int width = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mul_valid,
    input  logic                 mul_signed,
    input  logic [width-1:0]     a,
    input  logic [width-1:0]     b,
    output logic                 mul_valid_out,
    output logic [2*width-1:0]   product
);

    logic signed [width:0]       a_x;      // extra bit carries the sign
    logic signed [width:0]       b_x;
    logic signed [2*width+1:0]   prod_full;
    logic                        valid_s1;

    assign prod_full = a_x * b_x;

    // valid travels alongside the data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_s1      <= 1'b0;
            mul_valid_out <= 1'b0;
        end else begin
            valid_s1      <= mul_valid;
            mul_valid_out <= valid_s1;
        end
    end

    always_ff @(posedge clk) begin
        a_x     <= {mul_signed & a[width-1], a};
        b_x     <= {mul_signed & b[width-1], b};
        product <= prod_full[2*width-1:0]; // upper two bits are sign copies
    end

endmodule

// File: mult_div/mdu_div.sv
/*
 * Iterative restoring divider, signed and unsigned.
 * One load cycle, width shift-subtract steps and one
 * sign fix cycle that also raises done.
 * A zero divisor gives all ones and the dividend back.
 */
`timescale 1ns/100ps

module mdu_div #(
    parameter int width = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 div_start,
    input  logic                 div_signed,
    input  logic [width-1:0]     a,
    input  logic [width-1:0]     b,
    output logic                 done,
    output logic [width-1:0]     quotient,
    output logic [width-1:0]     remainder
);

    localparam int cnt_w = $clog2(width + 1);

    logic                 running;
    logic                 fixing;
    logic [cnt_w-1:0]     count;
    logic [width-1:0]     rem_r;
    logic [width-1:0]     quo_r;
    logic [width-1:0]     dvs_r;
    logic [width-1:0]     dividend_r;
    logic                 neg_q;
    logic                 neg_r;
    logic                 zero_div;
    logic                 neg_a;
    logic                 neg_b;
    logic [width:0]       shifted;
    logic [width:0]       diff;

    assign neg_a   = div_signed && a[width-1];
    assign neg_b   = div_signed && b[width-1];
    assign shifted = {rem_r, quo_r[width-1]};
    assign diff    = shifted - {1'b0, dvs_r};

    // sequencing flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
            fixing  <= 1'b0;
            done    <= 1'b0;
            count   <= '0;
        end else begin
            done   <= fixing;
            fixing <= 1'b0;
            if (div_start) begin
                running <= 1'b1;
                count   <= '0;
            end else if (running) begin
                count <= count + 1'b1;
                if (count == cnt_w'(width - 1)) begin
                    running <= 1'b0;
                    fixing  <= 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (div_start) begin
            rem_r      <= '0;
            quo_r      <= neg_a ? -a : a;
            dvs_r      <= neg_b ? -b : b;
            dividend_r <= a;
            neg_q      <= neg_a ^ neg_b;
            neg_r      <= neg_a;
            zero_div   <= (b == '0);
        end else if (running) begin
            if (!diff[width]) begin // fits, keep the difference
                rem_r <= diff[width-1:0];
                quo_r <= {quo_r[width-2:0], 1'b1};
            end else begin
                rem_r <= shifted[width-1:0];
                quo_r <= {quo_r[width-2:0], 1'b0};
            end
        end
        if (fixing) begin
            if (zero_div) begin
                quotient  <= '1;
                remainder <= dividend_r;
            end else begin
                quotient  <= neg_q ? -quo_r : quo_r;
                remainder <= neg_r ? -rem_r : rem_r;
            end
        end
    end

endmodule

// File: mult_div/mdu_hilo.sv
/*
 * Operation sequencer with the HI/LO result registers.
 * Launches the multiplier or divider, holds busy until
 * the unit reports and writes the result into HI/LO.
 */
`timescale 1ns/100ps

module mdu_hilo #(
    parameter int width = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  mdu_pkg::mdu_op_t     op,
    input  logic [width-1:0]     op_a,
    input  logic [width-1:0]     op_b,
    output logic                 mul_valid,
    output logic                 mul_signed,
    output logic                 div_start,
    output logic                 div_signed,
    input  logic                 mul_valid_out,
    input  logic                 done,
    input  logic [2*width-1:0]   product,
    input  logic [width-1:0]     quotient,
    input  logic [width-1:0]     remainder,
    output logic [width-1:0]     hi,
    output logic [width-1:0]     lo,
    output logic [width-1:0]     a,
    output logic [width-1:0]     b,
    output logic                 busy
);

    logic is_mult;
    logic is_div;

    assign is_mult = (op == mdu_pkg::op_mult) || (op == mdu_pkg::op_multu);
    assign is_div  = (op == mdu_pkg::op_div)  || (op == mdu_pkg::op_divu);

    // launch controls
    assign mul_valid  = start && is_mult;
    assign div_start  = start && is_div;
    assign mul_signed = (op == mdu_pkg::op_mult);
    assign div_signed = (op == mdu_pkg::op_div);
    assign a          = op_a;
    assign b          = op_b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (start && (is_mult || is_div)) begin
            busy <= 1'b1;
        end else if (mul_valid_out || done) begin
            busy <= 1'b0;
        end
    end

    // result registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (mul_valid_out) begin
            hi <= product[2*width-1:width];
            lo <= product[width-1:0];
        end else if (done) begin
            hi <= remainder;
            lo <= quotient;
        end else if (start && op == mdu_pkg::op_mthi) begin
            hi <= op_a;
        end else if (start && op == mdu_pkg::op_mtlo) begin
            lo <= op_a;
        end
    end

endmodule

// File: source/mdu_top.sv
/*
 * Top level of the multiply/divide peripheral.
 * Wishbone slave, HI/LO sequencer, multiplier and divider.
 */
`timescale 1ns/100ps

module mdu_top #(
    parameter int width = mdu_pkg::default_width
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [2:0]           wb_adr,
    input  logic [width-1:0]     wb_dat_w,
    output logic [width-1:0]     wb_dat_r,
    output logic                 wb_ack
);

    logic [width-1:0]     op_a, op_b;
    logic [width-1:0]     hi, lo;
    logic [width-1:0]     a, b;
    logic                 start, busy;
    mdu_pkg::mdu_op_t     op;
    logic                 mul_valid, mul_signed, mul_valid_out;
    logic                 div_start, div_signed, done;
    logic [2*width-1:0]   product;
    logic [width-1:0]     quotient, remainder;

    mdu_wb_slave #(.width(width)) u_wb_slave (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .wb_dat_r, .wb_ack, .hi, .lo, .busy, .op_a, .op_b, .start, .op
    );

    mdu_hilo #(.width(width)) u_hilo (
        .clk, .rst_n, .start, .op, .op_a, .op_b,
        .mul_valid, .mul_signed, .div_start, .div_signed,
        .mul_valid_out, .done, .product, .quotient, .remainder,
        .hi, .lo, .a, .b, .busy
    );

    mdu_mult #(.width(width)) u_mult (
        .clk, .rst_n, .mul_valid, .mul_signed, .a, .b, .mul_valid_out, .product
    );

    mdu_div #(.width(width)) u_div (
        .clk, .rst_n, .div_start, .div_signed, .a, .b, .done, .quotient, .remainder
    );

endmodule

// File: sim/tb_mdu.sv
/*
 * Testbench for the multiply/divide peripheral.
 * Clock and reset, Wishbone read/write tasks, busy polling,
 * xorshift operands and a reference model for HI/LO.
 * Checks reset values, multiply, divide, moves and command stalls.
 */
`timescale 1ns/100ps

module tb_mdu;

    localparam int width = mdu_pkg::default_width;

    logic               clk;
    logic               rst_n;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [2:0]         wb_adr;
    logic [width-1:0]   wb_dat_w;
    logic [width-1:0]   wb_dat_r;
    logic               wb_ack;
    logic [31:0]        rng_state;
    int                 cycle_count = 0;

    mdu_top #(.width(width)) u_mdu_top (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [width-1:0] expected,
                               input logic [width-1:0] actual);
        assert (actual === expected)
        else stop_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v ^= v << 13;
        v ^= v >> 17;
        v ^= v << 5;
        return v;
    endfunction

    task automatic next_random(output logic [width-1:0] value);
        logic [63:0] both;
        rng_state    = xorshift32(rng_state);
        both[63:32]  = rng_state;
        rng_state    = xorshift32(rng_state);
        both[31:0]   = rng_state;
        value        = width'(both);
    endtask

    // full product, sign or zero extended to double width
    function automatic logic [2*width-1:0] ref_product(input logic [width-1:0] x,
                                                       input logic [width-1:0] y,
                                                       input logic sgn);
        logic [2*width-1:0] xe;
        logic [2*width-1:0] ye;
        xe = sgn ? {{width{x[width-1]}}, x} : {{width{1'b0}}, x};
        ye = sgn ? {{width{y[width-1]}}, y} : {{width{1'b0}}, y};
        return xe * ye;
    endfunction

    // returns {remainder, quotient}, truncating toward zero
    function automatic logic [2*width-1:0] ref_divide(input logic [width-1:0] x,
                                                      input logic [width-1:0] y,
                                                      input logic sgn);
        logic [width-1:0] mx;
        logic [width-1:0] my;
        logic [width-1:0] q;
        logic [width-1:0] r;
        logic             neg_x;
        logic             neg_y;
        if (y == '0)
            return {x, {width{1'b1}}};
        neg_x = sgn && x[width-1];
        neg_y = sgn && y[width-1];
        mx = neg_x ? -x : x;
        my = neg_y ? -y : y;
        q  = mx / my;
        r  = mx % my;
        if (neg_x ^ neg_y)
            q = -q;
        if (neg_x)
            r = -r; // remainder follows the dividend
        return {r, q};
    endfunction

    task automatic wait_ack(input string what);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_ack && waited < 100);
        if (!wb_ack)
            stop_run($sformatf("no wb_ack within 100 cycles on %s", what));
    endtask

    task automatic bus_write(input logic [2:0] adr, input logic [width-1:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        wait_ack($sformatf("write to address %0d", adr));
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
    endtask

    task automatic bus_read(input logic [2:0] adr, output logic [width-1:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack($sformatf("read of address %0d", adr));
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // one idle cycle lets busy rise before polling starts
    task automatic issue_cmd(input mdu_pkg::mdu_op_t op);
        bus_write(mdu_pkg::reg_cmd, width'(op));
        @(posedge clk);
        #1;
    endtask

    task automatic wait_idle();
        logic [width-1:0] status;
        int               t0;
        t0 = cycle_count;
        bus_read(mdu_pkg::reg_status, status);
        while (status[0] && (cycle_count - t0) < 4 * width)
            bus_read(mdu_pkg::reg_status, status);
        if (status[0])
            stop_run("busy flag did not fall within the polling timeout");
    endtask

    task automatic run_and_check(input string name, input mdu_pkg::mdu_op_t op,
                                 input logic [width-1:0] x, input logic [width-1:0] y,
                                 input logic [2*width-1:0] expected);
        logic [width-1:0] rd;
        bus_write(mdu_pkg::reg_a, x);
        bus_write(mdu_pkg::reg_b, y);
        issue_cmd(op);
        wait_idle();
        bus_read(mdu_pkg::reg_hi, rd);
        check_value($sformatf("%s hi", name), expected[2*width-1:width], rd);
        bus_read(mdu_pkg::reg_lo, rd);
        check_value($sformatf("%s lo", name), expected[width-1:0], rd);
    endtask

    task automatic mult_both(input string name, input logic [width-1:0] x,
                             input logic [width-1:0] y);
        run_and_check({name, " mult"}, mdu_pkg::op_mult, x, y, ref_product(x, y, 1'b1));
        run_and_check({name, " multu"}, mdu_pkg::op_multu, x, y, ref_product(x, y, 1'b0));
    endtask

    task automatic div_both(input string name, input logic [width-1:0] x,
                            input logic [width-1:0] y);
        run_and_check({name, " div"}, mdu_pkg::op_div, x, y, ref_divide(x, y, 1'b1));
        run_and_check({name, " divu"}, mdu_pkg::op_divu, x, y, ref_divide(x, y, 1'b0));
    endtask

    initial begin
        logic [width-1:0] x;
        logic [width-1:0] y;
        logic [width-1:0] rd;
        logic [width-1:0] lo_keep;
        logic [width-1:0] minv;
        int               t_cmd;
        int               t_ack;
        minv      = {1'b1, {(width-1){1'b0}}};
        rng_state = 32'd19820;
        rst_n     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // reset state, no stray ack
        repeat (4) begin
            @(posedge clk);
            #1;
            assert (wb_ack === 1'b0) else stop_run("wb_ack rose without a bus access");
        end
        bus_read(mdu_pkg::reg_hi, rd);
        check_value("reset hi", '0, rd);
        bus_read(mdu_pkg::reg_lo, rd);
        check_value("reset lo", '0, rd);
        bus_read(mdu_pkg::reg_status, rd);
        check_value("reset status", '0, rd);

        for (int i = 0; i < 8; i++) begin
            next_random(x);
            next_random(y);
            mult_both("random", x, y);
        end
        mult_both("min*min", minv, minv);
        mult_both("min*-1", minv, '1);
        mult_both("-1*-1", '1, '1);
        mult_both("max*max", ~minv, ~minv);
        mult_both("0*-1", '0, '1);

        for (int i = 0; i < 8; i++) begin
            next_random(x);
            next_random(y);
            y = $signed(y) >>> x[3:0]; // vary divisor size
            div_both("random", x, y);
        end
        div_both("min/-1", minv, '1);
        div_both("-7/2", -width'(7), width'(2));
        div_both("7/-2", width'(7), -width'(2));
        div_both("-7/-2", -width'(7), -width'(2));
        div_both("x/0", x, '0);
        div_both("min/0", minv, '0);

        // moves touch only one register
        bus_read(mdu_pkg::reg_lo, lo_keep);
        next_random(x);
        next_random(y);
        run_and_check("mthi", mdu_pkg::op_mthi, x, y, {x, lo_keep});
        run_and_check("mtlo", mdu_pkg::op_mtlo, y, ~x, {x, y});

        // command written during a divide is stalled
        next_random(x);
        next_random(y);
        bus_write(mdu_pkg::reg_a, x);
        bus_write(mdu_pkg::reg_b, y | width'(1));
        issue_cmd(mdu_pkg::op_divu);
        t_cmd = cycle_count;
        next_random(x);
        next_random(y);
        bus_write(mdu_pkg::reg_a, x);
        bus_write(mdu_pkg::reg_b, y);
        bus_write(mdu_pkg::reg_cmd, width'(mdu_pkg::op_mult));
        t_ack = cycle_count;
        assert (t_ack - t_cmd >= width)
        else stop_run("command acked while the divide was still busy");
        @(posedge clk);
        #1;
        wait_idle();
        bus_read(mdu_pkg::reg_hi, rd);
        check_value("stalled mult hi", ref_product(x, y, 1'b1) >> width, rd);
        bus_read(mdu_pkg::reg_lo, rd);
        check_value("stalled mult lo", width'(ref_product(x, y, 1'b1)), rd);

        // busy window of a lone divide
        bus_write(mdu_pkg::reg_a, x);
        bus_write(mdu_pkg::reg_b, y);
        bus_write(mdu_pkg::reg_cmd, width'(mdu_pkg::op_div));
        t_cmd = cycle_count;
        @(posedge clk);
        #1;
        wait_idle();
        assert (cycle_count - t_cmd >= width)
        else stop_run("divide busy window shorter than the operand width");
        bus_read(mdu_pkg::reg_hi, rd);
        check_value("window div hi", ref_divide(x, y, 1'b1) >> width, rd);
        bus_read(mdu_pkg::reg_lo, rd);
        check_value("window div lo", width'(ref_divide(x, y, 1'b1)), rd);

        $display("No errors");
        $finish;
    end

endmodule

// File: sources.f
common/mdu_pkg.sv
source/mdu_wb_slave.sv
mult_div/mdu_mult.sv
mult_div/mdu_div.sv
mult_div/mdu_hilo.sv
source/mdu_top.sv
sim/tb_mdu.sv

// File: Bender.yml
package:
  name: mdu

sources:
  - common/mdu_pkg.sv
  - source/mdu_wb_slave.sv
  - mult_div/mdu_mult.sv
  - mult_div/mdu_div.sv
  - mult_div/mdu_hilo.sv
  - source/mdu_top.sv
  - target: simulation
    files:
      - sim/tb_mdu.sv
